// File: common/warpPkg.sv
`default_nettype none

package warpPkg;

	// fast-bus region, decoded once per strobe cycle.
	typedef enum logic [2:0] {
		regNone,	// no cycle or unmapped.
		regRam,		// DRAM below romBase.
		regRom,		// boot ROM.
		regIo,		// bridged onto the slow bus.
		regIack		// interrupt acknowledge, answered with vpaN.
	} regionT;

	// DRAM controller states, CPU access first and refresh after.
	typedef enum logic [2:0] {
		ramIdle,	// free slot for CPU or refresh.
		ramRas,		// row strobe.
		ramCas,		// column strobe, ready rises.
		ramHold,	// held until the strobe ends, also the ROM access.
		refCas,		// CAS before RAS.
		refRas,
		refRecover	// precharge.
	} ramStateT;

	// shared by the slow-bus slave and master.
	typedef enum logic [1:0] {
		ioIdle,
		ioStrobe,
		ioWaitAck,
		ioDone
	} ioStateT;

	// address map on addr[23:20].
	localparam logic [3:0] ramTop = 4'h3;	// RAM is 0 through 3.
	localparam logic [3:0] romBase = 4'h4;
	localparam logic [3:0] ioBase = 4'h5;	// I/O runs to F.

	// addr[23:4] all ones marks an iack cycle.
	localparam logic [19:0] iackPrefix = 20'hFFFFF;

endpackage

`default_nettype wire

// File: src/chipSelect.sv
`default_nettype none

module chipSelect import warpPkg::*; (
	input wire FCLK,
	input wire rstN,
	input wire [23:8] addr,
	input wire asN,
	output logic bact,
	output regionT region
);

	regionT decode;	// combinational region of the current address.

	always_comb begin
		if (addr[23:8] == iackPrefix[19:4]) begin
			decode = regIack;	// checked first, it sits inside I/O space.
		end else if (addr[23:20] <= ramTop) begin
			decode = regRam;
		end else if (addr[23:20] == romBase) begin
			decode = regRom;
		end else if (addr[23:20] >= ioBase) begin
			decode = regIo;
		end else begin
			decode = regNone;
		end
	end

	// bact follows the strobe one edge late.
	// region is taken on the first edge of the cycle and kept.
	always_ff @(posedge FCLK or negedge rstN) begin
		if (!rstN) begin
			bact <= 1'b0;
			region <= regNone;
		end else begin
			bact <= !asN;
			if (asN) begin
				region <= regNone;	// strobe gone.
			end else if (!bact) begin
				region <= decode;	// cycle 0 edge only.
			end
		end
	end

endmodule

`default_nettype wire

// File: ram/refreshTimer.sv
`default_nettype none

module refreshTimer #(
	parameter logic [15:0] refreshPeriod = 16'd64
) (
	input wire FCLK,
	input wire rstN,
	input wire refAck,
	output logic refReq
);

	logic [15:0] cnt;	// free-running down-counter.
	logic wrap;

	assign wrap = cnt == 16'd0;

	always_ff @(posedge FCLK or negedge rstN) begin
		if (!rstN) begin
			cnt <= refreshPeriod - 16'd1;
			refReq <= 1'b0;
		end else begin
			// reload keeps the spacing fixed whatever the ack latency.
			cnt <= wrap ? refreshPeriod - 16'd1 : cnt - 16'd1;
			if (wrap) begin
				refReq <= 1'b1;	// sticky until acked.
			end else if (refAck) begin
				refReq <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// File: ram/ramCtl.sv
`default_nettype none

module ramCtl import warpPkg::*; #(
	parameter logic [3:0] romWaitCycles = 4'd2
) (
	input wire FCLK,
	input wire rstN,
	input wire [21:1] addr,
	input wire weN,
	input wire ldsN,
	input wire udsN,
	input wire bact,
	input wire regionT region,
	input wire refReq,
	output logic refAck,
	output logic ramReady,
	output logic [11:0] ra,
	output logic rasN,
	output logic casN,
	output logic oeN,
	output logic ramLweN,
	output logic ramUweN,
	output logic romCsN
);

	ramStateT state;
	logic romSel;			// the hold slot is a ROM access.
	logic [3:0] waitCnt;	// ROM wait states left.
	logic cpuStart;
	logic refStart;
	logic colPhase;
	logic romAct;

	// arbiter: the CPU always wins a shared idle slot.
	assign cpuStart = (state == ramIdle) && bact && (region == regRam || region == regRom);
	assign refStart = (state == ramIdle) && refReq && !cpuStart;
	assign refAck = refStart;	// one pulse, the FSM leaves idle at once.

	always_ff @(posedge FCLK or negedge rstN) begin
		if (!rstN) begin
			state <= ramIdle;
			romSel <= 1'b0;
			waitCnt <= 4'd0;
		end else begin
			case (state)
				ramIdle: begin
					if (cpuStart) begin
						romSel <= region == regRom;
						waitCnt <= romWaitCycles;
						// ROM skips the row and column phases.
						state <= (region == regRom) ? ramHold : ramRas;
					end else if (refStart) begin
						state <= refCas;
					end
				end
				ramRas: state <= ramCas;
				ramCas: state <= ramHold;
				ramHold: begin
					if (waitCnt != 4'd0) begin
						waitCnt <= waitCnt - 4'd1;
					end
					if (!bact) begin
						state <= ramIdle;	// CPU dropped the strobe.
					end
				end
				refCas: state <= refRas;
				refRas: state <= refRecover;
				refRecover: state <= ramIdle;
				default: state <= ramIdle;
			endcase
		end
	end

	assign colPhase = (state == ramCas) || (state == ramHold && !romSel);
	assign romAct = (state == ramHold) && romSel;

	// row then column on the same pins.
	assign ra = colPhase ? {2'b00, addr[10:1]} : {1'b0, addr[21:11]};

	// RAS covers row and column, CAS leads it on refresh.
	assign rasN = !(state == ramRas || colPhase || state == refRas);
	assign casN = !(colPhase || state == refCas || state == refRas);
	assign oeN = !((colPhase && weN) || romAct);	// read only.

	// byte lanes gated by the strobes.
	assign ramLweN = !(colPhase && !weN && !ldsN);
	assign ramUweN = !(colPhase && !weN && !udsN);
	assign romCsN = !romAct;

	assign ramReady = colPhase || (romAct && waitCnt == 4'd0);

endmodule

`default_nettype wire

// File: iobus/iobSlave.sv
`default_nettype none

module iobSlave import warpPkg::*; (
	input wire FCLK,
	input wire rstN,
	input wire weN,
	input wire bact,
	input wire regionT region,
	input wire ioDone,
	input wire ioBerr,
	output logic ioRdReq,
	output logic ioWrReq,
	output logic ioReady,
	output logic ioBerrOut
);

	// the ioDone state shares its name with the port, so it is scoped.
	ioStateT state;
	logic isRead;	// direction of the outstanding request.
	logic errSeen;	// master ended it with a bus error.

	always_ff @(posedge FCLK or negedge rstN) begin
		if (!rstN) begin
			state <= ioIdle;
			isRead <= 1'b1;
			errSeen <= 1'b0;
		end else begin
			case (state)
				ioIdle: begin
					if (bact && region == regIo) begin
						isRead <= weN;
						state <= ioStrobe;	// one request per cycle.
					end
				end
				ioStrobe: state <= ioWaitAck;
				ioWaitAck: begin
					if (ioDone) begin
						errSeen <= ioBerr;	// valid with the done pulse.
						state <= warpPkg::ioDone;
					end
				end
				warpPkg::ioDone: begin
					if (!bact) begin
						state <= ioIdle;
					end
				end
				default: state <= ioIdle;
			endcase
		end
	end

	// request pulse is the single ioStrobe cycle.
	assign ioRdReq = (state == ioStrobe) && isRead;
	assign ioWrReq = (state == ioStrobe) && !isRead;

	// result held until the CPU ends the cycle.
	assign ioReady = (state == warpPkg::ioDone) && !errSeen;
	assign ioBerrOut = (state == warpPkg::ioDone) && errSeen;

endmodule

`default_nettype wire

// File: iobus/iobMaster.sv
`default_nettype none

module iobMaster import warpPkg::*; (
	input wire FCLK,
	input wire rstN,
	input wire [23:1] addr,
	input wire ldsN,
	input wire udsN,
	input wire ioRdReq,
	input wire ioWrReq,
	input wire iobDtackN,
	input wire iobBerrN,
	output logic ioDone,
	output logic ioBerr,
	output logic [23:1] iobAddr,
	output logic iobAoe,
	output logic iobAsN,
	output logic iobLdsN,
	output logic iobUdsN
);

	ioStateT state;
	logic [1:0] dtackSync;	// two flops, the slow bus is asynchronous.
	logic [1:0] berrSync;
	logic ldsLat;
	logic udsLat;
	logic berrLat;
	logic busAct;
	logic ackSeen;

	// both terminations reset to idle high.
	always_ff @(posedge FCLK or negedge rstN) begin
		if (!rstN) begin
			dtackSync <= 2'b11;
			berrSync <= 2'b11;
		end else begin
			dtackSync <= {dtackSync[0], iobDtackN};
			berrSync <= {berrSync[0], iobBerrN};
		end
	end

	assign ackSeen = !dtackSync[1] || !berrSync[1];

	// address and strobes captured with the request.
	always_ff @(posedge FCLK) begin
		if (state == ioIdle && (ioRdReq || ioWrReq)) begin
			iobAddr <= addr;
			ldsLat <= ldsN;	// write direction rides on these.
			udsLat <= udsN;
		end
	end

	always_ff @(posedge FCLK or negedge rstN) begin
		if (!rstN) begin
			state <= ioIdle;
			berrLat <= 1'b0;
		end else begin
			case (state)
				ioIdle: begin
					if (ioRdReq || ioWrReq) begin
						state <= ioStrobe;
					end
				end
				ioStrobe: state <= ioWaitAck;	// strobes low at least two cycles.
				ioWaitAck: begin
					if (ackSeen) begin
						berrLat <= !berrSync[1];	// berr wins over dtack.
						state <= warpPkg::ioDone;
					end
				end
				warpPkg::ioDone: state <= ioIdle;	// one-cycle done pulse.
				default: state <= ioIdle;
			endcase
		end
	end

	assign busAct = (state == ioStrobe) || (state == ioWaitAck);

	assign iobAoe = busAct;
	assign iobAsN = !busAct;
	assign iobLdsN = ldsLat || !busAct;
	assign iobUdsN = udsLat || !busAct;

	assign ioDone = state == warpPkg::ioDone;
	assign ioBerr = (state == warpPkg::ioDone) && berrLat;

endmodule

`default_nettype wire

// File: src/fsbTerm.sv
`default_nettype none

module fsbTerm import warpPkg::*; (
	input wire FCLK,
	input wire rstN,
	input wire bact,
	input wire regionT region,
	input wire ramReady,
	input wire ioReady,
	input wire ioBerrOut,
	output logic dtackN,
	output logic vpaN,
	output logic berrN
);

	logic iackArm;	// delays vpaN to cycle 2.
	logic memCyc;
	logic ioCyc;
	logic iackCyc;

	assign memCyc = region == regRam || region == regRom;
	assign ioCyc = region == regIo;
	assign iackCyc = region == regIack;

	always_ff @(posedge FCLK or negedge rstN) begin
		if (!rstN) begin
			dtackN <= 1'b1;
			vpaN <= 1'b1;
			berrN <= 1'b1;
			iackArm <= 1'b0;
		end else if (!bact) begin
			dtackN <= 1'b1;	// release everything with the strobe.
			vpaN <= 1'b1;
			berrN <= 1'b1;
			iackArm <= 1'b0;
		end else begin
			iackArm <= iackCyc;
			// sticky until bact falls.
			if ((memCyc && ramReady) || (ioCyc && ioReady)) begin
				dtackN <= 1'b0;
			end
			if (ioCyc && ioBerrOut) begin
				berrN <= 1'b0;
			end
			if (iackCyc && iackArm) begin
				vpaN <= 1'b0;	// autovector.
			end
		end
	end

endmodule

`default_nettype wire

// File: src/warpSe.sv
`default_nettype none

module warpSe import warpPkg::*; #(
	parameter logic [15:0] refreshPeriod = 16'd64,
	parameter logic [3:0] romWaitCycles = 4'd2
) (
	input wire FCLK,
	input wire rstN,
	input wire [23:1] addr,
	input wire asN,
	input wire ldsN,
	input wire udsN,
	input wire weN,
	output wire dtackN,
	output wire vpaN,
	output wire berrN,
	output wire [11:0] ra,
	output wire rasN,
	output wire casN,
	output wire oeN,
	output wire ramLweN,
	output wire ramUweN,
	output wire romCsN,
	output wire [23:1] iobAddr,
	output wire iobAoe,
	output wire iobAsN,
	output wire iobLdsN,
	output wire iobUdsN,
	input wire iobDtackN,
	input wire iobBerrN
);

	logic bact;			// strobe cycle active.
	regionT region;
	logic refReq;
	logic refAck;
	logic ramReady;		// DRAM or ROM data valid.
	logic ioRdReq;
	logic ioWrReq;
	logic ioDone;
	logic ioBerr;
	logic ioReady;
	logic ioBerrOut;

	chipSelect cs_i (
		.FCLK(FCLK), .rstN(rstN),
		.addr(addr[23:8]), .asN(asN),
		.bact(bact), .region(region)
	);

	refreshTimer #(.refreshPeriod(refreshPeriod)) refresh_i (
		.FCLK(FCLK), .rstN(rstN),
		.refAck(refAck), .refReq(refReq)
	);

	// only arbiter, CPU against refresh.
	ramCtl #(.romWaitCycles(romWaitCycles)) ram_i (
		.FCLK(FCLK), .rstN(rstN),
		.addr(addr[21:1]), .weN(weN), .ldsN(ldsN), .udsN(udsN),
		.bact(bact), .region(region), .refReq(refReq),
		.refAck(refAck), .ramReady(ramReady), .ra(ra),
		.rasN(rasN), .casN(casN), .oeN(oeN),
		.ramLweN(ramLweN), .ramUweN(ramUweN), .romCsN(romCsN)
	);

	iobSlave iobSlave_i (
		.FCLK(FCLK), .rstN(rstN),
		.weN(weN), .bact(bact), .region(region),
		.ioDone(ioDone), .ioBerr(ioBerr),
		.ioRdReq(ioRdReq), .ioWrReq(ioWrReq),
		.ioReady(ioReady), .ioBerrOut(ioBerrOut)
	);

	iobMaster iobMaster_i (
		.FCLK(FCLK), .rstN(rstN),
		.addr(addr), .ldsN(ldsN), .udsN(udsN),
		.ioRdReq(ioRdReq), .ioWrReq(ioWrReq),
		.iobDtackN(iobDtackN), .iobBerrN(iobBerrN),
		.ioDone(ioDone), .ioBerr(ioBerr),
		.iobAddr(iobAddr), .iobAoe(iobAoe), .iobAsN(iobAsN),
		.iobLdsN(iobLdsN), .iobUdsN(iobUdsN)
	);

	fsbTerm fsb_i (
		.FCLK(FCLK), .rstN(rstN),
		.bact(bact), .region(region),
		.ramReady(ramReady), .ioReady(ioReady), .ioBerrOut(ioBerrOut),
		.dtackN(dtackN), .vpaN(vpaN), .berrN(berrN)
	);

endmodule

`default_nettype wire

// File: verification/clkGen.sv
`default_nettype none

module clkGen #(
	parameter int resetCycles = 5
) (
	output logic FCLK,
	output logic rstN
);

	initial begin
		FCLK = 1'b0;
		forever #2 FCLK = !FCLK;	// period of 4.
	end

	// reset held low over the first edges, released on a rising edge.
	initial begin
		rstN = 1'b0;
		repeat (resetCycles) @(posedge FCLK);
		rstN <= 1'b1;
	end

endmodule

`default_nettype wire

// File: verification/warpTb.sv
`default_nettype none

module warpTb;

	localparam logic [15:0] refreshPeriod = 16'd64;
	localparam logic [3:0] romWaitCycles = 4'd2;
	localparam int testCount = 14;	// bus cycles plus the refresh spacing run.
	localparam int histDepth = 64;

	wire FCLK;
	wire rstN;
	logic [23:1] addr;
	logic asN;
	logic ldsN;
	logic udsN;
	logic weN;
	logic iobDtackN;
	logic iobBerrN;
	wire dtackN;
	wire vpaN;
	wire berrN;
	wire [11:0] ra;
	wire rasN;
	wire casN;
	wire oeN;
	wire ramLweN;
	wire ramUweN;
	wire romCsN;
	wire [23:1] iobAddr;
	wire iobAoe;
	wire iobAsN;
	wire iobLdsN;
	wire iobUdsN;

	logic [31:0] lfsrState;
	int cycleCnt = 0;
	int termCycle;		// edge index of the first termination.
	time termTime;
	time ackTime;		// when the responder terminated the slow cycle.
	time ioEndTime;
	logic [23:1] iobAddrSeen;
	logic iobLdsSeen;
	logic iobUdsSeen;
	logic iobAoeSeen;

	// pin history of one bus cycle, index is the edge count from cycle 0.
	logic rasHist [histDepth];
	logic casHist [histDepth];
	logic [11:0] raHist [histDepth];
	logic oeHist [histDepth];
	logic lweHist [histDepth];
	logic uweHist [histDepth];
	logic romCsHist [histDepth];
	logic dtackHist [histDepth];
	logic vpaHist [histDepth];
	logic berrHist [histDepth];
	logic iobAsHist [histDepth];

	clkGen clk_i (.FCLK(FCLK), .rstN(rstN));

	warpSe #(.refreshPeriod(refreshPeriod), .romWaitCycles(romWaitCycles)) dut_i (
		.FCLK(FCLK), .rstN(rstN),
		.addr(addr), .asN(asN), .ldsN(ldsN), .udsN(udsN), .weN(weN),
		.dtackN(dtackN), .vpaN(vpaN), .berrN(berrN),
		.ra(ra), .rasN(rasN), .casN(casN), .oeN(oeN),
		.ramLweN(ramLweN), .ramUweN(ramUweN), .romCsN(romCsN),
		.iobAddr(iobAddr), .iobAoe(iobAoe), .iobAsN(iobAsN),
		.iobLdsN(iobLdsN), .iobUdsN(iobUdsN),
		.iobDtackN(iobDtackN), .iobBerrN(iobBerrN)
	);

	always @(posedge FCLK) cycleCnt <= cycleCnt + 1;

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			abortRun($sformatf("mismatch %s expected %0h actual %0h", name, expected, actual));
		end
	endtask

	// right-shift Galois form, taps 32 22 2 1.
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic randBits(input int n, output logic [31:0] val);
		int i;
		val = '0;
		for (i = 0; i < n; i++) begin
			lfsrState = lfsrNext(lfsrState);	// one step per bit.
			val = {val[30:0], lfsrState[0]};
		end
	endtask

	// one CPU cycle, held until a termination shows, then released.
	task automatic fsbCycle(input logic [23:0] byteAddr, input logic write,
			input logic lds, input logic uds);
		int k;
		int rel;
		logic done;
		k = 0;
		rel = 0;
		done = 1'b0;
		@(posedge FCLK);
		addr <= byteAddr[23:1];
		weN <= !write;
		ldsN <= lds;
		udsN <= uds;
		asN <= 1'b0;
		while (!done) begin
			@(posedge FCLK);
			@(negedge FCLK);	// outputs settled after edge k.
			if (k >= histDepth) begin
				abortRun("bus cycle ran past the recorded history");
			end
			rasHist[k] = rasN;
			casHist[k] = casN;
			raHist[k] = ra;
			oeHist[k] = oeN;
			lweHist[k] = ramLweN;
			uweHist[k] = ramUweN;
			romCsHist[k] = romCsN;
			dtackHist[k] = dtackN;
			vpaHist[k] = vpaN;
			berrHist[k] = berrN;
			iobAsHist[k] = iobAsN;
			if (!dtackN || !vpaN || !berrN) begin
				done = 1'b1;
			end else begin
				k++;
			end
		end
		termCycle = k;
		termTime = $time;
		@(posedge FCLK);
		asN <= 1'b1;
		ldsN <= 1'b1;
		udsN <= 1'b1;
		weN <= 1'b1;
		while (!dtackN || !vpaN || !berrN) begin
			@(negedge FCLK);
			rel++;
			if (rel > 4) begin
				abortRun("terminations still asserted after asN rose");
			end
		end
	endtask

	// slow-bus peer, answers after 1 to 8 cycles.
	task automatic iobResponder(input logic useBerr);
		logic [31:0] d;
		int n;
		n = 0;
		@(negedge FCLK);
		while (iobAsN) begin
			@(negedge FCLK);
			n++;
			if (n > 16) begin
				abortRun("slow-bus cycle never started");
			end
		end
		iobAddrSeen = iobAddr;
		iobLdsSeen = iobLdsN;
		iobUdsSeen = iobUdsN;
		iobAoeSeen = iobAoe;
		randBits(3, d);
		repeat (d[2:0] + 4'd1) @(posedge FCLK);
		if (useBerr) begin
			iobBerrN <= 1'b0;
		end else begin
			iobDtackN <= 1'b0;
		end
		ackTime = $time;
		n = 0;
		while (!iobAsN) begin
			@(negedge FCLK);
			n++;
			if (n > 16) begin
				abortRun("slow-bus strobe not released after the acknowledge");
			end
		end
		ioEndTime = $time;
		check("io strobes released lds", 1, iobLdsN);
		check("io strobes released uds", 1, iobUdsN);
		check("io aoe dropped", 0, iobAoe);
		@(posedge FCLK);
		iobDtackN <= 1'b1;
		iobBerrN <= 1'b1;
	endtask

	// returns at the sample of the next CAS-before-RAS slot.
	task automatic waitRefCas(output int t);
		int n;
		n = 0;
		@(negedge FCLK);
		while (!(!casN && rasN)) begin
			@(negedge FCLK);
			n++;
			if (n > 2 * refreshPeriod + 8) begin
				abortRun("no refresh seen on the DRAM pins");
			end
		end
		t = cycleCnt;
	endtask

	task automatic waitRefreshEnd();
		int t;
		waitRefCas(t);
		while (!casN) @(negedge FCLK);	// bounded by the refresh itself.
	endtask

	task automatic testResetState();
		check("reset dtackN", 1, dtackN);
		check("reset vpaN", 1, vpaN);
		check("reset berrN", 1, berrN);
		check("reset rasN", 1, rasN);
		check("reset casN", 1, casN);
		check("reset oeN", 1, oeN);
		check("reset romCsN", 1, romCsN);
		check("reset ramLweN", 1, ramLweN);
		check("reset ramUweN", 1, ramUweN);
		check("reset iobAsN", 1, iobAsN);
		check("reset iobLdsN", 1, iobLdsN);
		check("reset iobUdsN", 1, iobUdsN);
		check("reset iobAoe", 0, iobAoe);
	endtask

	task automatic testRamRead();
		logic [23:0] a;
		int k;
		a = 24'h2A5B3C;
		waitRefreshEnd();	// no refresh can be pending now.
		fsbCycle(a, 1'b0, 1'b0, 1'b0);
		check("ramRead rasN cycle 0", 1, rasHist[0]);
		check("ramRead rasN cycle 1", 0, rasHist[1]);
		check("ramRead casN cycle 1", 1, casHist[1]);
		check("ramRead row", {1'b0, a[21:11]}, raHist[1]);
		check("ramRead casN cycle 2", 0, casHist[2]);
		check("ramRead column", {2'b00, a[10:1]}, raHist[2]);
		check("ramRead oeN", 0, oeHist[2]);
		check("ramRead latency", 3, termCycle);
		check("ramRead dtackN", 0, dtackHist[termCycle]);
		for (k = 0; k <= termCycle; k++) begin
			check("ramRead ramLweN", 1, lweHist[k]);
			check("ramRead ramUweN", 1, uweHist[k]);
		end
	endtask

	task automatic testByteWrites();
		int i;
		int k;
		logic lds;
		logic uds;
		for (i = 0; i < 4; i++) begin
			lds = i[0];
			uds = i[1];
			waitRefreshEnd();
			fsbCycle(24'h13C6A4, 1'b1, lds, uds);
			check($sformatf("byteWrite lds=%0b uds=%0b ramLweN", lds, uds), lds, lweHist[2]);
			check($sformatf("byteWrite lds=%0b uds=%0b ramUweN", lds, uds), uds, uweHist[2]);
			for (k = 0; k <= termCycle; k++) begin
				check("byteWrite oeN", 1, oeHist[k]);
				if (casHist[k]) begin
					check("byteWrite ramLweN outside cas", 1, lweHist[k]);
					check("byteWrite ramUweN outside cas", 1, uweHist[k]);
				end
			end
		end
	endtask

	task automatic testRefresh();
		int t0;
		int t1;
		int k;
		int rowK;
		logic [23:0] a;
		// bus idle, CAS leads RAS.
		waitRefCas(t0);
		@(negedge FCLK);
		check("refresh casN in ras slot", 0, casN);
		check("refresh rasN in ras slot", 0, rasN);
		@(negedge FCLK);
		check("refresh casN recover", 1, casN);
		check("refresh rasN recover", 1, rasN);
		waitRefCas(t1);
		check("refresh spacing", refreshPeriod, t1 - t0);
		// CPU cycle lands on a running refresh.
		a = 24'h35A7D2;
		waitRefCas(t0);
		fsbCycle(a, 1'b0, 1'b0, 1'b0);
		rowK = -1;
		for (k = termCycle; k >= 0; k--) begin
			if (!rasHist[k] && casHist[k]) begin
				rowK = k;
			end
		end
		if (rowK < 0) begin
			abortRun("RAM cycle after a refresh showed no row phase");
		end
		check("refreshOverlap row", {1'b0, a[21:11]}, raHist[rowK]);
		check("refreshOverlap casN", 0, casHist[rowK + 1]);
		check("refreshOverlap column", {2'b00, a[10:1]}, raHist[rowK + 1]);
		check("refreshOverlap dtackN", 0, dtackHist[termCycle]);
		check("refreshOverlap latency at least 3", 1, termCycle >= 3);
	endtask

	task automatic testRomRead();
		int k;
		fsbCycle(24'h41F2C0, 1'b0, 1'b0, 1'b0);
		check("romRead romCsN", 0, romCsHist[1]);
		check("romRead oeN", 0, oeHist[1]);
		check("romRead latency", 1 + romWaitCycles + 1, termCycle);
		check("romRead dtackN", 0, dtackHist[termCycle]);
		for (k = 0; k <= termCycle; k++) begin
			check("romRead rasN", 1, rasHist[k]);
		end
	endtask

	task automatic testIoBridge();
		int n;
		logic [31:0] r;
		logic [3:0] top;
		logic [23:0] a;
		logic write;
		logic lds;
		logic uds;
		logic useBerr;
		for (n = 0; n < 5; n++) begin
			randBits(3, r);
			top = 4'h5 + {1'b0, r[2:0]};	// 5 through C, never iack.
			randBits(19, r);
			a = {top, r[18:0], 1'b0};
			write = n[0];
			randBits(2, r);
			lds = write && r[0];
			uds = write && r[1] && !r[0];	// at least one lane active.
			useBerr = n == 4;
			fork
				fsbCycle(a, write, lds, uds);
				iobResponder(useBerr);
			join
			check("io iobAddr", a[23:1], iobAddrSeen);
			check("io iobLdsN", lds, iobLdsSeen);
			check("io iobUdsN", uds, iobUdsSeen);
			check("io iobAoe", 1, iobAoeSeen);
			check("io dtackN", useBerr, dtackHist[termCycle]);
			check("io berrN", !useBerr, berrHist[termCycle]);
			check("io termination after ack", 1, termTime > ackTime);
			check("io strobes after ack", 1, ioEndTime > ackTime);
		end
	endtask

	task automatic testIack();
		int k;
		fsbCycle(24'hFFFFFA, 1'b0, 1'b0, 1'b0);
		check("iack vpaN cycle 1", 1, vpaHist[1]);
		check("iack vpaN cycle 2", 0, vpaHist[2]);
		check("iack latency", 2, termCycle);
		for (k = 0; k <= termCycle; k++) begin
			check("iack dtackN", 1, dtackHist[k]);
			check("iack berrN", 1, berrHist[k]);
			check("iack slow bus idle", 1, iobAsHist[k]);
		end
	endtask

	initial begin
		repeat (testCount * 200) @(posedge FCLK);
		abortRun("watchdog expired before the tests finished");
	end

	initial begin
		addr = '0;
		asN = 1'b1;
		ldsN = 1'b1;
		udsN = 1'b1;
		weN = 1'b1;
		iobDtackN = 1'b1;
		iobBerrN = 1'b1;
		lfsrState = 32'h1660;
		@(posedge rstN);
		@(negedge FCLK);
		testResetState();
		testRamRead();
		testByteWrites();
		testRefresh();
		testRomRead();
		testIoBridge();
		testIack();
		$display("Test completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
common/warpPkg.sv
src/chipSelect.sv
ram/refreshTimer.sv
ram/ramCtl.sv
iobus/iobSlave.sv
iobus/iobMaster.sv
src/fsbTerm.sv
src/warpSe.sv
verification/clkGen.sv
verification/warpTb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
rm -rf obj_dir sim.log &&
verilator --binary --timing -Wno-fatal --top-module warpTb -f vlog.f -o warpSim &&
./obj_dir/warpSim | tee sim.log
grep -q "Test completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
